// File: coreConfig_config.svh
/*
 * Core configuration
 * Word width, memory depths and register count of the pipelined core
 */
`ifndef CORECONFIG_CONFIG_SVH
`define CORECONFIG_CONFIG_SVH

// One machine word, also the instruction width
`define DATA_W 16

// Instruction memory depth in words
`define IMEM_DEPTH 256

// Data memory depth in words
`define DMEM_DEPTH 256

// Architectural registers
`define NUM_REGS 8

`endif

// File: corePkg.sv
/*
 * Core types
 * Opcode encoding and the payloads carried between pipeline stages
 */
`include "coreConfig_config.svh"

package corePkg;

   localparam int DataW = `DATA_W;
   localparam int RegAW = $clog2(`NUM_REGS);
   localparam int ImemAW = $clog2(`IMEM_DEPTH);
   localparam int DmemAW = $clog2(`DMEM_DEPTH);

   typedef logic [DataW-1:0] wordT;
   typedef logic [RegAW-1:0] regAddrT;
   typedef logic [`NUM_REGS-1:0] regMaskT;
   typedef logic [ImemAW-1:0] imemAddrT;
   typedef logic [DmemAW-1:0] dmemAddrT;

   // Instruction bits 15 to 12, codes above opHalt are illegal
   typedef enum logic [3:0] {
      opNop  = 4'h0,
      opAdd  = 4'h1,
      opSub  = 4'h2,
      opAnd  = 4'h3,
      opXor  = 4'h4,
      opAddi = 4'h5,
      opLdi  = 4'h6,
      opLd   = 4'h7,
      opSt   = 4'h8,
      opBeqz = 4'h9,
      opHalt = 4'ha
   } opcodeT;

   typedef struct packed {
      logic valid;
      wordT pc;
      wordT instr;
   } fetchDecT;

   typedef struct packed {
      logic valid;
      opcodeT op;
      regAddrT dest;
      logic writesReg;
      wordT opA;
      wordT opB;    // Second source, or store data for ST
      wordT imm;
      wordT pc;
   } decExT;

   typedef struct packed {
      logic valid;
      opcodeT op;
      regAddrT dest;
      logic writesReg;
      wordT result; // ALU result or effective address
      wordT storeData;
      logic isHalt;
   } exMemT;

   typedef struct packed {
      logic valid;
      regAddrT dest;
      logic writesReg;
      wordT data;
      logic isHalt;
   } memWbT;

   typedef struct packed {
      logic valid;
      regAddrT regAddr;
      wordT data;
   } retireT;

   // One-hot mask of the register a stage will still write
   function automatic regMaskT pendMask(input logic writes, input regAddrT dest);
      regMaskT mask;
      mask = '0;
      if (writes) begin
         mask[dest] = 1'b1;
      end
      return mask;
   endfunction

endpackage

// File: pipeReg.sv
/*
 * Pipeline stage register
 * Holds its payload on stall and loads an empty bubble on flush
 */
`timescale 1ns/1ns

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // A bubble is the all-zero payload, so its valid bit is clear
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         q <= '0;
      end else if (flush) begin
         // Flush wins, the stalled instruction is on the wrong path
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// File: fetchStage.sv
/*
 * Fetch stage
 * Program counter, instruction memory with its load port and branch redirect
 */
`timescale 1ns/1ns
`include "coreConfig_config.svh"

module fetchStage import corePkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  logic     run,
   input  logic     stall,
   input  logic     redirect,
   input  wordT     target,
   input  logic     halted,
   input  logic     progWe,
   input  imemAddrT progAddr,
   input  wordT     progData,
   output fetchDecT out
);

   wordT imem [`IMEM_DEPTH];
   wordT pc;
   wordT instr;
   logic active;
   logic atHalt;

   // Program load, only used while the core is idle
   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   assign instr = imem[pc[ImemAW-1:0]];
   assign active = run && !halted;

   // Parking on HALT keeps anything past the end of the program out of the pipe
   assign atHalt = opcodeT'(instr[15:12]) == opHalt;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= target;
      end else if (active && !stall && !atHalt) begin
         pc <= pc + wordT'(1);
      end
   end

   assign out.valid = active;
   assign out.pc = pc;
   assign out.instr = instr;

endmodule

// File: regFile.sv
/*
 * Register file
 * Two combinational read ports, one write port, same-cycle write-through
 */
`timescale 1ns/1ns
`include "coreConfig_config.svh"

module regFile import corePkg::*; (
   input  logic    clk,
   input  logic    arstN,
   input  regAddrT rdAddrA,
   input  regAddrT rdAddrB,
   output wordT    rdDataA,
   output wordT    rdDataB,
   input  logic    we,
   input  regAddrT wrAddr,
   input  wordT    wrData
);

   wordT regs [`NUM_REGS];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-back in the same cycle is seen by decode
   assign rdDataA = (we && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (we && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: decodeStage.sv
/*
 * Decode stage
 * Field split, immediate extension, dependence interlock and illegal opcode trap
 */
`timescale 1ns/1ns

module decodeStage import corePkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  fetchDecT in,
   input  regMaskT  exPend,
   input  regMaskT  memPend,
   input  regMaskT  wbPend,
   input  memWbT    wrPort,
   output decExT    out,
   output logic     stall,
   output logic     err
);

   opcodeT  op;
   regAddrT rd;
   regAddrT rs;
   regAddrT rt;
   regAddrT addrA;
   regAddrT addrB;
   wordT    imm6;
   wordT    imm9;
   wordT    rdDataA;
   wordT    rdDataB;
   logic    usesA;
   logic    usesB;
   logic    writes;
   logic    legal;
   logic    issue;
   regMaskT busy;

   assign op = opcodeT'(in.instr[15:12]);
   assign rd = in.instr[11:9];
   assign rs = in.instr[8:6];
   assign rt = in.instr[5:3];
   assign imm6 = {{(DataW-6){in.instr[5]}}, in.instr[5:0]};
   assign imm9 = {{(DataW-9){in.instr[8]}}, in.instr[8:0]};

   always_comb begin : classify
      usesA = 1'b0;
      usesB = 1'b0;
      writes = 1'b0;
      legal = 1'b1;
      case (op)
         opNop, opHalt: legal = 1'b1;
         opAdd, opSub, opAnd, opXor: begin
            usesA = 1'b1;
            usesB = 1'b1;
            writes = 1'b1;
         end
         opAddi, opLd: begin
            usesA = 1'b1;
            writes = 1'b1;
         end
         opLdi: writes = 1'b1;
         opSt: begin
            usesA = 1'b1;
            usesB = 1'b1;
         end
         opBeqz: usesA = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   // BEQZ tests rd, ST stores rd
   assign addrA = (op == opBeqz) ? rd : rs;
   assign addrB = (op == opSt) ? rd : rt;

   // Write-back enables exactly the register it still marks pending
   regFile regs_i (
      .clk    (clk),
      .arstN  (arstN),
      .rdAddrA(addrA),
      .rdAddrB(addrB),
      .rdDataA(rdDataA),
      .rdDataB(rdDataB),
      .we     (|wbPend),
      .wrAddr (wrPort.dest),
      .wrData (wrPort.data)
   );

   // Older writers still in execute or memory block the read
   assign busy = exPend | memPend;
   assign stall = in.valid && ((usesA && busy[addrA]) || (usesB && busy[addrB]));
   assign issue = in.valid && legal && !stall;

   always_comb begin
      out.valid = issue;
      out.op = op;
      out.dest = rd;
      out.writesReg = issue && writes;
      out.opA = rdDataA;
      out.opB = rdDataB;
      out.imm = (op == opLdi || op == opBeqz) ? imm9 : imm6;
      out.pc = in.pc;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         err <= 1'b0;
      end else if (in.valid && !legal) begin
         err <= 1'b1;
      end
   end

endmodule

// File: executeStage.sv
/*
 * Execute stage
 * ALU, effective address adder and BEQZ resolution
 */
`timescale 1ns/1ns

module executeStage import corePkg::*; (
   input  decExT   in,
   output exMemT   out,
   output logic    redirect,
   output wordT    target,
   output regMaskT exPend
);

   wordT sum;
   wordT ea;
   wordT aluOut;

   assign sum = in.opA + in.imm;

   // Addresses wrap inside the data memory
   assign ea = wordT'(sum[DmemAW-1:0]);

   always_comb begin : alu
      case (in.op)
         opAdd:       aluOut = in.opA + in.opB;
         opSub:       aluOut = in.opA - in.opB;
         opAnd:       aluOut = in.opA & in.opB;
         opXor:       aluOut = in.opA ^ in.opB;
         opAddi:      aluOut = sum;
         opLdi:       aluOut = in.imm;
         opLd, opSt:  aluOut = ea;
         default:     aluOut = '0;
      endcase
   end

   always_comb begin
      out.valid = in.valid;
      out.op = in.op;
      out.dest = in.dest;
      out.writesReg = in.writesReg;
      out.result = aluOut;
      out.storeData = in.opB;
      out.isHalt = in.valid && in.op == opHalt;
   end

   // Taken branch, target is relative to the next PC
   assign redirect = in.valid && in.op == opBeqz && in.opA == '0;
   assign target = in.pc + wordT'(1) + in.imm;

   assign exPend = pendMask(in.writesReg, in.dest);

endmodule

// File: memoryStage.sv
/*
 * Memory stage
 * Data memory access, store strobe and write-back data select
 */
`timescale 1ns/1ns
`include "coreConfig_config.svh"

module memoryStage import corePkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  exMemT    in,
   output memWbT    out,
   output logic     storeValid,
   output dmemAddrT storeAddr,
   output wordT     storeData,
   output regMaskT  memPend
);

   wordT     dmem [`DMEM_DEPTH];
   dmemAddrT addr;
   logic     isStore;
   logic     isLoad;

   assign addr = in.result[DmemAW-1:0];
   assign isStore = in.valid && in.op == opSt;
   assign isLoad = in.op == opLd;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (isStore) begin
         dmem[addr] <= in.storeData;
      end
   end

   always_comb begin
      out.valid = in.valid;
      out.dest = in.dest;
      out.writesReg = in.writesReg;
      out.data = isLoad ? dmem[addr] : in.result;
      out.isHalt = in.isHalt;
   end

   // Each ST sits here for one cycle only
   assign storeValid = isStore;
   assign storeAddr = addr;
   assign storeData = in.storeData;

   assign memPend = pendMask(in.writesReg, in.dest);

endmodule

// File: procCore.sv
/*
 * Processor core
 * Five-stage in-order pipeline, halt tracking and the error flag
 */
`timescale 1ns/1ns

module procCore import corePkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  logic     run,
   input  logic     progWe,
   input  imemAddrT progAddr,
   input  wordT     progData,
   output retireT   retire,
   output logic     storeValid,
   output dmemAddrT storeAddr,
   output wordT     storeData,
   output logic     halted,
   output logic     err
);

   fetchDecT fetchD;
   fetchDecT fetchQ;
   decExT    decD;
   decExT    decQ;
   exMemT    exD;
   exMemT    exQ;
   memWbT    memD;
   memWbT    memQ;
   logic     decStall;
   logic     redirect;
   wordT     target;
   regMaskT  exPend;
   regMaskT  memPend;
   regMaskT  wbPend;
   logic     decErr;

   fetchStage fetch_i (
      .clk(clk), .arstN(arstN), .run(run), .stall(decStall),
      .redirect(redirect), .target(target), .halted(halted),
      .progWe(progWe), .progAddr(progAddr), .progData(progData), .out(fetchD)
   );

   pipeReg #(.payloadT(fetchDecT)) fdReg_i (
      .clk(clk), .arstN(arstN), .stall(decStall), .flush(redirect), .d(fetchD), .q(fetchQ)
   );

   decodeStage decode_i (
      .clk(clk), .arstN(arstN), .in(fetchQ), .exPend(exPend), .memPend(memPend),
      .wbPend(wbPend), .wrPort(memQ), .out(decD), .stall(decStall), .err(decErr)
   );

   pipeReg #(.payloadT(decExT)) deReg_i (
      .clk(clk), .arstN(arstN), .stall(1'b0), .flush(redirect), .d(decD), .q(decQ)
   );

   executeStage execute_i (
      .in(decQ), .out(exD), .redirect(redirect), .target(target), .exPend(exPend)
   );

   pipeReg #(.payloadT(exMemT)) emReg_i (
      .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(exD), .q(exQ)
   );

   memoryStage memory_i (
      .clk(clk), .arstN(arstN), .in(exQ), .out(memD), .storeValid(storeValid),
      .storeAddr(storeAddr), .storeData(storeData), .memPend(memPend)
   );

   pipeReg #(.payloadT(memWbT)) mwReg_i (
      .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(memD), .q(memQ)
   );

   // Write-back stage drives the register file through decode
   assign wbPend = pendMask(memQ.valid && memQ.writesReg, memQ.dest);
   assign retire.valid = memQ.valid && memQ.writesReg;
   assign retire.regAddr = memQ.dest;
   assign retire.data = memQ.data;

   // Sticky until reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
      end else if (memQ.valid && memQ.isHalt) begin
         halted <= 1'b1;
      end
   end

   assign err = decErr;

endmodule

// File: procCore_tb.sv
/*
 * Testbench for the pipelined core
 * Runs seeded random programs and one illegal-opcode program,
 * comparing retirements and stores with a reference interpreter
 */
`timescale 1ns/1ns
`include "coreConfig_config.svh"

module procCore_tb import corePkg::*; ;

   localparam int NumPrograms = 12;
   localparam int HaltTimeout = 4000;

   logic     clk;
   logic     arstN;
   logic     run;
   logic     progWe;
   imemAddrT progAddr;
   wordT     progData;
   retireT   retire;
   logic     storeValid;
   dmemAddrT storeAddr;
   wordT     storeData;
   logic     halted;
   logic     err;

   integer      seed;
   logic        expectErr;
   wordT        prog [`IMEM_DEPTH];
   logic [18:0] expRegQ [$];
   logic [23:0] expStQ [$];

   procCore dut_i (
      .clk(clk), .arstN(arstN), .run(run), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .retire(retire), .storeValid(storeValid),
      .storeAddr(storeAddr), .storeData(storeData), .halted(halted), .err(err)
   );

   always #20 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         failRun($sformatf("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
      end
   endtask

   function automatic int randBelow(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic wordT encodeReg(input opcodeT op, input regAddrT rd, input regAddrT rs,
                                      input regAddrT rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic wordT encodeImm6(input opcodeT op, input regAddrT rd, input regAddrT rs,
                                       input int imm);
      return {op, rd, rs, imm[5:0]};
   endfunction

   function automatic wordT encodeImm9(input opcodeT op, input regAddrT rd, input int imm);
      return {op, rd, imm[8:0]};
   endfunction

   // Interprets the program and queues every register write and store in order
   function automatic void interpretProgram(input int len);
      wordT     regs [`NUM_REGS];
      wordT     mem [`DMEM_DEPTH];
      wordT     instr;
      wordT     imm6;
      wordT     imm9;
      wordT     a;
      wordT     b;
      wordT     val;
      dmemAddrT addr;
      regAddrT  rd;
      int       pc;
      int       steps;
      logic     wr;
      logic     done;
      expRegQ.delete();
      expStQ.delete();
      for (int i = 0; i < `NUM_REGS; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < `DMEM_DEPTH; i++) begin
         mem[i] = '0;
      end
      pc = 0;
      steps = 0;
      done = 1'b0;
      while (!done && pc < len && steps < 4 * `IMEM_DEPTH) begin
         instr = prog[pc];
         rd = instr[11:9];
         imm6 = {{10{instr[5]}}, instr[5:0]};
         imm9 = {{7{instr[8]}}, instr[8:0]};
         a = regs[instr[8:6]];
         b = regs[instr[5:3]];
         addr = dmemAddrT'(a + imm6);
         pc = pc + 1;
         steps = steps + 1;
         wr = instr[15:12] inside {opAdd, opSub, opAnd, opXor, opAddi, opLdi, opLd};
         val = '0;
         case (instr[15:12])
            opAdd: val = a + b;
            opSub: val = a - b;
            opAnd: val = a & b;
            opXor: val = a ^ b;
            opAddi: val = a + imm6;
            opLdi: val = imm9;
            opLd: val = mem[addr];
            opSt: begin
               mem[addr] = regs[rd];
               expStQ.push_back({addr, regs[rd]});
            end
            opBeqz: begin
               // Offset counts from the instruction after the branch
               if (regs[rd] == '0) begin
                  pc = pc + int'($signed(imm9));
               end
            end
            opHalt: done = 1'b1;
            default: ;  // NOP and illegal codes leave no trace
         endcase
         if (wr) begin
            regs[rd] = val;
            expRegQ.push_back({rd, val});
         end
      end
   endfunction

   task automatic genProgram(output int len);
      int      maxOff;
      regAddrT rd;
      regAddrT rs;
      regAddrT rt;
      len = 24 + randBelow(24);
      for (int i = 0; i < len - 1; i++) begin
         rd = regAddrT'(randBelow(8));
         rs = regAddrT'(randBelow(8));
         rt = regAddrT'(randBelow(8));
         maxOff = (len - 2 - i < 4) ? len - 2 - i : 4;
         case (randBelow(12))
            0: prog[i] = encodeReg(opAdd, rd, rs, rt);
            1: prog[i] = encodeReg(opSub, rd, rs, rt);
            2: prog[i] = encodeReg(opAnd, rd, rs, rt);
            3: prog[i] = encodeReg(opXor, rd, rs, rt);
            4: prog[i] = encodeImm6(opAddi, rd, rs, randBelow(64));
            5, 6: prog[i] = encodeImm9(opLdi, rd, randBelow(16) - 4);
            // Small offsets so loads meet earlier stores
            7: prog[i] = encodeImm6(opLd, rd, rs, randBelow(8));
            8: prog[i] = encodeImm6(opSt, rd, rs, randBelow(8));
            9, 10: prog[i] = encodeImm9(opBeqz, rd, randBelow(maxOff + 1));
            default: prog[i] = encodeImm9(opNop, 3'd0, 0);
         endcase
      end
      prog[len-1] = encodeImm9(opHalt, 3'd0, 0);
   endtask

   task automatic applyReset();
      @(posedge clk);
      arstN <= 1'b0;
      run <= 1'b0;
      repeat (4) @(posedge clk);
      arstN <= 1'b1;
   endtask

   task automatic loadProgram(input int len);
      for (int i = 0; i < len; i++) begin
         @(posedge clk);
         progWe <= 1'b1;
         progAddr <= imemAddrT'(i);
         progData <= prog[i];
      end
      @(posedge clk);
      progWe <= 1'b0;
   endtask

   task automatic runProgram(input int len, input logic errExpected);
      int cycles;
      applyReset();
      expectErr = errExpected;
      loadProgram(len);
      interpretProgram(len);
      @(posedge clk);
      run <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!halted) begin
         if (cycles >= HaltTimeout) begin
            failRun("Timed out waiting for the core to halt");
         end
         @(negedge clk);
         cycles++;
      end
      // Let the pipeline drain behind the halt
      repeat (6) @(negedge clk);
      checkEq("register writes still expected", 32'(expRegQ.size()), 32'd0);
      checkEq("stores still expected", 32'(expStQ.size()), 32'd0);
      checkEq("err after halt", 32'(err), 32'(errExpected));
      @(posedge clk);
      run <= 1'b0;
   endtask

   always @(negedge clk) begin : compareEvents
      logic [18:0] expReg;
      logic [23:0] expSt;
      if (arstN) begin
         if (retire.valid) begin
            if (halted) begin
               failRun("A register write retired after the core halted");
            end else if (expRegQ.size() == 0) begin
               failRun("A register write retired that the program never makes");
            end else begin
               expReg = expRegQ.pop_front();
               checkEq("retired register", 32'(retire.regAddr), 32'(expReg[18:16]));
               checkEq("retired data", 32'(retire.data), 32'(expReg[15:0]));
            end
         end
         if (storeValid) begin
            if (halted) begin
               failRun("A store appeared after the core halted");
            end else if (expStQ.size() == 0) begin
               failRun("A store appeared that the program never makes");
            end else begin
               expSt = expStQ.pop_front();
               checkEq("store address", 32'(storeAddr), 32'(expSt[23:16]));
               checkEq("store data", 32'(storeData), 32'(expSt[15:0]));
            end
         end
         if (!expectErr) begin
            checkEq("err", 32'(err), 32'd0);
         end
      end
   end

   initial begin : mainFlow
      int len;
      clk = 1'b0;
      arstN = 1'b0;
      run = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      expectErr = 1'b0;
      seed = 32'hfab185fc;
      for (int p = 0; p < NumPrograms; p++) begin
         genProgram(len);
         runProgram(len, 1'b0);
      end
      // Illegal opcode between two legal writes and a store
      prog[0] = encodeImm9(opLdi, 3'd1, 5);
      prog[1] = 16'hf000;
      prog[2] = encodeImm6(opAddi, 3'd2, 3'd1, 1);
      prog[3] = encodeImm6(opSt, 3'd2, 3'd0, 3);
      prog[4] = encodeImm9(opHalt, 3'd0, 0);
      runProgram(5, 1'b1);
      applyReset();
      @(negedge clk);
      checkEq("err after reset", 32'(err), 32'd0);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: src.f
+incdir+.
corePkg.sv
pipeReg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
procCore.sv
procCore_tb.sv

// File: run.sh
#!/bin/bash
# Build the core testbench with Verilator and run it

verilator --binary --timing -Wno-fatal --top-module procCore_tb -f src.f -o procCore_sim \
   || { echo "Verilator build failed"; exit 1; }

simOut="$(./obj_dir/procCore_sim 2>&1)"
echo "$simOut"

echo "$simOut" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" \
   || { echo "Simulation did not pass"; exit 1; }
